/* src/dramPkg.sv */
// Shared widths, depths and latency of the synthetic DRAM front end
// Depths need not be powers of two; pointers wrap explicitly
`default_nettype none

package dramPkg;

	//--------------------------------------------------
	// Data path
	//--------------------------------------------------
	localparam int DataWidth = 64;             // One DRAM word
	localparam int ByteWidth = 8;
	localparam int MaskWidth = DataWidth / ByteWidth; // Bit set means byte kept
	localparam int AddrWidth = 6;              // Word address
	localparam int MemWords = 1 << AddrWidth;

	//--------------------------------------------------
	// Queues and latency
	//--------------------------------------------------
	localparam int CmdQueueDepth = 4;          // Input buffer of commands
	localparam int WriteQueueDepth = 4;        // Pending write data words
	localparam int ReadLatency = 4;            // Issue edge to readValid

	// Pointer and occupancy widths
	localparam int CmdPtrWidth = (CmdQueueDepth > 1) ? $clog2(CmdQueueDepth) : 1;
	localparam int CmdCountWidth = $clog2(CmdQueueDepth + 1);
	localparam int WritePtrWidth = (WriteQueueDepth > 1) ? $clog2(WriteQueueDepth) : 1;
	localparam int WriteCountWidth = $clog2(WriteQueueDepth + 1);

	// Same encoding as the DDR3 controller app_cmd
	typedef enum logic [2:0] {
		cmdWrite = 3'd0,
		cmdRead  = 3'd1
	} dramCmdT;

endpackage

`default_nettype wire

/* src/commandQueue.sv */
// Requester command FIFO; only cmdWrite and cmdRead may be sent
// Anything that is not a write at the head is treated as a read
`default_nettype none

module commandQueue
	import dramPkg::*;
(
	input wire logic MemoryClock,
	input wire logic arstN,

	// Requester side
	input wire logic cmdValid,
	input wire dramCmdT cmd,
	input wire logic [AddrWidth-1:0] addr,
	output logic cmdReady,

	// Head toward the write join
	input wire logic headPop,
	output logic headValid,
	output logic headIsWrite,
	output logic [AddrWidth-1:0] headAddr
);

	//--------------------------------------------------
	// Storage and pointers
	//--------------------------------------------------
	dramCmdT cmdMem [CmdQueueDepth];
	logic [AddrWidth-1:0] addrMem [CmdQueueDepth];

	logic [CmdPtrWidth-1:0] wrPtr;
	logic [CmdPtrWidth-1:0] rdPtr;
	logic [CmdCountWidth-1:0] count;

	logic push;
	logic pop;

	assign cmdReady = (count != CmdCountWidth'(CmdQueueDepth)); // Full stalls requester
	assign headValid = (count != '0);

	assign push = cmdValid & cmdReady;
	assign pop = headPop & headValid;   // Join only pops a valid head

	// Decode once here so the join never sees raw encoding
	assign headIsWrite = (cmdMem[rdPtr] == cmdWrite);
	assign headAddr = addrMem[rdPtr];

	// Payload only, no reset
	always_ff @(posedge MemoryClock) begin
		if (push) begin
			cmdMem[wrPtr] <= cmd;
			addrMem[wrPtr] <= addr;
		end
	end

	//--------------------------------------------------
	// Control
	//--------------------------------------------------
	always_ff @(posedge MemoryClock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				// Wrap at depth
				wrPtr <= (wrPtr == CmdPtrWidth'(CmdQueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == CmdPtrWidth'(CmdQueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/writeJoin.sv */
// Releases a write command only in the same cycle as its data word
// A write without data blocks every command queued behind it
`default_nettype none

module writeJoin
	import dramPkg::*;
(
	input wire logic MemoryClock,
	input wire logic arstN,

	// Requester write channel
	input wire logic writeValid,
	input wire logic [DataWidth-1:0] writeData,
	input wire logic [MaskWidth-1:0] writeMask,
	output logic writeReady,

	// Command queue head
	input wire logic headValid,
	input wire logic headIsWrite,
	input wire logic [AddrWidth-1:0] headAddr,
	output logic headPop,

	// Issue into memory, no ready
	output logic issueValid,
	output logic issueWrite,
	output logic [AddrWidth-1:0] issueAddr,
	output logic [DataWidth-1:0] issueData,
	output logic [MaskWidth-1:0] issueMask
);

	//--------------------------------------------------
	// Write data FIFO
	//--------------------------------------------------
	logic [DataWidth-1:0] dataMem [WriteQueueDepth];
	logic [MaskWidth-1:0] maskMem [WriteQueueDepth];

	logic [WritePtrWidth-1:0] wrPtr;
	logic [WritePtrWidth-1:0] rdPtr;
	logic [WriteCountWidth-1:0] count;

	logic dataValid;
	logic push;
	logic pop;

	assign writeReady = (count != WriteCountWidth'(WriteQueueDepth));
	assign dataValid = (count != '0);
	assign push = writeValid & writeReady;

	// Join rule: reads go at once, writes wait for data
	assign issueValid = headValid & (~headIsWrite | dataValid);
	assign headPop = issueValid;
	assign pop = issueValid & headIsWrite;  // Data leaves with its command

	assign issueWrite = headIsWrite;
	assign issueAddr = headAddr;
	assign issueData = dataMem[rdPtr];
	assign issueMask = maskMem[rdPtr];

	always_ff @(posedge MemoryClock) begin
		if (push) begin
			dataMem[wrPtr] <= writeData;
			maskMem[wrPtr] <= writeMask;
		end
	end

	always_ff @(posedge MemoryClock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == WritePtrWidth'(WriteQueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == WritePtrWidth'(WriteQueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/memoryArray.sv */
// Synthetic DRAM: byte-masked writes, reads return after exactly ReadLatency edges
// Storage powers up undefined; ReadLatency must be at least 2
`default_nettype none

module memoryArray
	import dramPkg::*;
(
	input wire logic MemoryClock,
	input wire logic arstN,

	// One issue per cycle from the join
	input wire logic issueValid,
	input wire logic issueWrite,
	input wire logic [AddrWidth-1:0] issueAddr,
	input wire logic [DataWidth-1:0] issueData,
	input wire logic [MaskWidth-1:0] issueMask,

	// Read return, no back-pressure
	output logic readValid,
	output logic [DataWidth-1:0] readData
);

	//--------------------------------------------------
	// Storage
	//--------------------------------------------------
	logic [DataWidth-1:0] mem [MemWords];

	logic writeIssue;
	logic readIssue;

	assign writeIssue = issueValid & issueWrite;
	assign readIssue = issueValid & ~issueWrite;

	// Mask bit 1 keeps the old byte, DDR3 style
	always_ff @(posedge MemoryClock) begin
		if (writeIssue) begin
			for (int b = 0; b < MaskWidth; b++) begin
				if (!issueMask[b])
					mem[issueAddr][b*ByteWidth +: ByteWidth] <=
						issueData[b*ByteWidth +: ByteWidth];
			end
		end
	end

	//--------------------------------------------------
	// Read pipeline
	//--------------------------------------------------
	logic [ReadLatency-1:0] pipeValid;          // Bit 0 is the youngest stage
	logic [DataWidth-1:0] pipeData [ReadLatency];

	// Valid bits only
	always_ff @(posedge MemoryClock or negedge arstN) begin
		if (!arstN) begin
			pipeValid <= '0;
		end else begin
			pipeValid <= {pipeValid[ReadLatency-2:0], readIssue};
		end
	end

	// Data shifts every cycle, bubbles carry stale words
	always_ff @(posedge MemoryClock) begin
		pipeData[0] <= mem[issueAddr];           // Sampled at the issue edge
		for (int s = 1; s < ReadLatency; s++) begin
			pipeData[s] <= pipeData[s-1];
		end
	end

	// Last stage drives the port
	assign readValid = pipeValid[ReadLatency-1];
	assign readData = pipeData[ReadLatency-1];

endmodule

`default_nettype wire

/* src/dramFrontEnd.sv */
// Memory side of the board: command queue, write join and synthetic DRAM
// All logic on MemoryClock; read data has no ready and must be taken at once
`default_nettype none

module dramFrontEnd
	import dramPkg::*;
(
	input wire logic MemoryClock,
	input wire logic arstN,

	// Command channel
	input wire logic cmdValid,
	input wire dramCmdT cmd,
	input wire logic [AddrWidth-1:0] addr,
	output logic cmdReady,

	// Write data channel
	input wire logic writeValid,
	input wire logic [DataWidth-1:0] writeData,
	input wire logic [MaskWidth-1:0] writeMask,
	output logic writeReady,

	// Read return
	output logic readValid,
	output logic [DataWidth-1:0] readData
);

	//--------------------------------------------------
	// Internal wires
	//--------------------------------------------------
	logic headValid;
	logic headIsWrite;
	logic [AddrWidth-1:0] headAddr;
	logic headPop;                      // Join back to queue

	logic issueValid;
	logic issueWrite;
	logic [AddrWidth-1:0] issueAddr;
	logic [DataWidth-1:0] issueData;
	logic [MaskWidth-1:0] issueMask;

	commandQueue u_commandQueue (
		.MemoryClock(MemoryClock), .arstN(arstN),
		.cmdValid(cmdValid), .cmd(cmd), .addr(addr), .cmdReady(cmdReady),
		.headPop(headPop), .headValid(headValid),
		.headIsWrite(headIsWrite), .headAddr(headAddr)
	);

	// Command and data meet here
	writeJoin u_writeJoin (
		.MemoryClock(MemoryClock), .arstN(arstN),
		.writeValid(writeValid), .writeData(writeData),
		.writeMask(writeMask), .writeReady(writeReady),
		.headValid(headValid), .headIsWrite(headIsWrite),
		.headAddr(headAddr), .headPop(headPop),
		.issueValid(issueValid), .issueWrite(issueWrite), .issueAddr(issueAddr),
		.issueData(issueData), .issueMask(issueMask)
	);

	memoryArray u_memoryArray (
		.MemoryClock(MemoryClock), .arstN(arstN),
		.issueValid(issueValid), .issueWrite(issueWrite), .issueAddr(issueAddr),
		.issueData(issueData), .issueMask(issueMask),
		.readValid(readValid), .readData(readData)
	);

endmodule

`default_nettype wire

/* sim/dramFrontEndTb.sv */
// Testbench for the DRAM front end; fills every word first so random reads are defined
// Stops at the first mismatch; needs a simulator with timing support
`default_nettype none

module dramFrontEndTb
	import dramPkg::*;
();

	localparam int TimeoutCycles = 200;         // Per wait loop
	localparam logic [AddrWidth-1:0] PlainAddr = 6'd5;
	localparam logic [AddrWidth-1:0] MaskAddr = 6'd9;
	localparam logic [AddrWidth-1:0] WaitBase = 6'd32;  // Four stalled writes from here

	logic MemoryClock;
	logic arstN;
	logic cmdValid;
	dramCmdT cmd;
	logic [AddrWidth-1:0] addr;
	logic cmdReady;
	logic writeValid;
	logic [DataWidth-1:0] writeData;
	logic [MaskWidth-1:0] writeMask;
	logic writeReady;
	logic readValid;
	logic [DataWidth-1:0] readData;

	integer seed = 87;
	string testName = "resetState";
	logic [DataWidth-1:0] refMem [MemWords];    // Reference memory
	logic [DataWidth-1:0] expQ [$];             // Expected read data, command order

	dramFrontEnd u_dramFrontEnd (
		.MemoryClock(MemoryClock), .arstN(arstN),
		.cmdValid(cmdValid), .cmd(cmd), .addr(addr), .cmdReady(cmdReady),
		.writeValid(writeValid), .writeData(writeData),
		.writeMask(writeMask), .writeReady(writeReady),
		.readValid(readValid), .readData(readData)
	);

	always #5 MemoryClock = ~MemoryClock;

	//--------------------------------------------------
	// Failure reporting
	//--------------------------------------------------
	task automatic abortRun(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic failValue(input string name, input logic [DataWidth-1:0] expected,
			input logic [DataWidth-1:0] actual);
		abortRun($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		assert (actual === expected) else failValue(name, DataWidth'(expected), DataWidth'(actual));
	endtask

	//--------------------------------------------------
	// Reference model
	//--------------------------------------------------
	// Mask bit 1 keeps the old byte
	function automatic void maskedUpdate(input logic [AddrWidth-1:0] a,
			input logic [DataWidth-1:0] d, input logic [MaskWidth-1:0] m);
		for (int b = 0; b < MaskWidth; b++) begin
			if (!m[b])
				refMem[a][b*8 +: 8] = d[b*8 +: 8];
		end
	endfunction

	// Every byte carries the full address
	function automatic logic [DataWidth-1:0] fillWord(input logic [AddrWidth-1:0] a);
		return {MaskWidth{2'b10, a}};
	endfunction

	//--------------------------------------------------
	// Stimulus, called 1 unit after a rising edge
	//--------------------------------------------------
	task automatic driveChannels(input logic withCmd, input dramCmdT c,
			input logic [AddrWidth-1:0] a, input logic withData,
			input logic [DataWidth-1:0] d, input logic [MaskWidth-1:0] m);
		logic cmdDone;
		logic dataDone;
		int waited;
		cmdDone = !withCmd;
		dataDone = !withData;
		waited = 0;
		if (withCmd) begin
			cmdValid = 1'b1;
			cmd = c;
			addr = a;
		end
		if (withData) begin
			writeValid = 1'b1;
			writeData = d;
			writeMask = m;
		end
		while (!(cmdDone && dataDone)) begin
			@(posedge MemoryClock);
			waited++;
			if (withCmd && cmdValid && cmdReady)
				cmdDone = 1'b1;
			if (withData && writeValid && writeReady)
				dataDone = 1'b1;
			if (!(cmdDone && dataDone) && waited >= TimeoutCycles)
				abortRun("Timeout: a command or write data word was never accepted");
			#1;
			if (withCmd && cmdDone)
				cmdValid = 1'b0;
			if (withData && dataDone)
				writeValid = 1'b0;
		end
	endtask

	task automatic writeWord(input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] d,
			input logic [MaskWidth-1:0] m);
		driveChannels(1'b1, cmdWrite, a, 1'b1, d, m);
		maskedUpdate(a, d, m);
	endtask

	task automatic readWord(input logic [AddrWidth-1:0] a);
		driveChannels(1'b1, cmdRead, a, 1'b0, '0, '0);   // Monitor queues the expected word
	endtask

	task automatic drainReads();
		int waited;
		waited = 0;
		while (expQ.size() != 0) begin
			@(posedge MemoryClock);
			#1;                                 // Monitor has popped by now
			waited++;
			if (expQ.size() != 0 && waited >= TimeoutCycles)
				abortRun("Timeout: read data did not come back");
		end
	endtask

	task automatic waitForCmdSpace();
		int waited;
		waited = 0;
		do begin
			@(posedge MemoryClock);
			waited++;
			if (!cmdReady && waited >= TimeoutCycles)
				abortRun("Timeout: the command queue never accepted commands again");
		end while (!cmdReady);
		#1;
	endtask

	//--------------------------------------------------
	// Read return checks, sampled at the edge
	//--------------------------------------------------
	always @(posedge MemoryClock) begin : readMonitor
		logic [DataWidth-1:0] expected;
		if (readValid) begin
			assert (expQ.size() != 0) else abortRun("readValid arrived with no read outstanding");
			expected = expQ.pop_front();
			assert (readData === expected) else failValue(testName, expected, readData);
		end
		if (cmdValid && cmdReady && cmd == cmdRead)
			expQ.push_back(refMem[addr]);
	end

	initial begin : stimulus
		logic [DataWidth-1:0] firstWord;
		logic [DataWidth-1:0] waitData [4];
		MemoryClock = 1'b0;
		arstN = 1'b0;
		cmdValid = 1'b0;
		cmd = cmdWrite;
		addr = '0;
		writeValid = 1'b0;
		writeData = '0;
		writeMask = '0;

		// 1: idle outputs during and after reset
		repeat (3) @(posedge MemoryClock);
		#1;
		checkBit(testName, 1'b0, readValid);
		checkBit(testName, 1'b1, cmdReady);
		checkBit(testName, 1'b1, writeReady);
		repeat (2) @(posedge MemoryClock);
		#1;
		arstN = 1'b1;
		@(posedge MemoryClock);
		#1;
		checkBit(testName, 1'b0, readValid);
		checkBit(testName, 1'b1, cmdReady);
		checkBit(testName, 1'b1, writeReady);

		testName = "memoryFill";
		for (int a = 0; a < MemWords; a++)
			writeWord(AddrWidth'(a), fillWord(AddrWidth'(a)), '0);

		// 2: plain write then read
		testName = "writeThenRead";
		writeWord(PlainAddr, {$random(seed), $random(seed)}, '0);
		readWord(PlainAddr);
		drainReads();

		// 3: second write keeps masked bytes
		testName = "byteMask";
		firstWord = {$random(seed), $random(seed)};
		writeWord(MaskAddr, firstWord, '0);
		writeWord(MaskAddr, {$random(seed), $random(seed)}, MaskWidth'($random(seed)));
		readWord(MaskAddr);
		drainReads();

		// 4: four writes stall the queue until their data shows up
		testName = "writeWaitsForData";
		for (int i = 0; i < 4; i++)
			driveChannels(1'b1, cmdWrite, AddrWidth'(WaitBase + i), 1'b0, '0, '0);
		checkBit(testName, 1'b0, cmdReady);
		cmdValid = 1'b1;                        // Read held off by the full queue
		cmd = cmdRead;
		addr = PlainAddr;
		repeat (6) begin
			@(posedge MemoryClock);
			checkBit(testName, 1'b0, cmdReady);
			checkBit(testName, 1'b0, readValid);
		end
		#1;
		for (int i = 0; i < 4; i++)
			waitData[i] = {$random(seed), $random(seed)};
		fork
			driveChannels(1'b1, cmdRead, PlainAddr, 1'b0, '0, '0);
			begin
				for (int i = 0; i < 4; i++) begin
					driveChannels(1'b0, cmdRead, '0, 1'b1, waitData[i], '0);
					maskedUpdate(AddrWidth'(WaitBase + i), waitData[i], '0);
				end
			end
		join
		waitForCmdSpace();
		for (int i = 0; i < 4; i++)
			readWord(AddrWidth'(WaitBase + i));
		drainReads();

		// 5: reads back to back, several in flight
		testName = "backToBackReads";
		for (int i = 0; i < 16; i++)
			readWord(AddrWidth'($random(seed)));
		drainReads();

		repeat (2) @(posedge MemoryClock);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* dramFrontEnd.f */
src/dramPkg.sv
src/commandQueue.sv
src/writeJoin.sv
src/memoryArray.sv
src/dramFrontEnd.sv
sim/dramFrontEndTb.sv

/* run.sh */
#!/bin/sh
# Builds the DRAM front end testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

TOP=dramFrontEndTb
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" -o "$TOP" \
	-f dramFrontEnd.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

"./$BUILD_DIR/$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0
